/* rtl/smul_pkg.sv */
/*
  Shared widths, lane positions and request/response types for the
  lane-split multiplier. The lane layout is fixed at 8/8/16/32 bits.
  Changing a lane position needs a matching change of the lane types.
*/
package smul_pkg;

  //////////////////////////////////////////////////
  // word and lane geometry
  //////////////////////////////////////////////////
  localparam int NUM_LANES = 4;   // lanes per operand word
  localparam int WORD_W    = 64;  // data / weight / result word

  localparam int LANE0_LSB = 0;   // 8 bit lane
  localparam int LANE1_LSB = 8;   // 8 bit lane
  localparam int LANE2_LSB = 16;  // 16 bit lane
  localparam int LANE3_LSB = 32;  // 32 bit lane, built from halves

  localparam int HALF_W    = 16;  // partial product width of lane 3

  //////////////////////////////////////////////////
  // value types
  //////////////////////////////////////////////////
  typedef logic [WORD_W-1:0]    word_t;
  typedef logic [NUM_LANES-1:0] prec_mask_t;  // bit n enables lane n

  typedef logic [7:0]  lane8_t;
  typedef logic [15:0] lane16_t;
  typedef logic [31:0] lane32_t;

  //////////////////////////////////////////////////
  // request / response
  //////////////////////////////////////////////////
  typedef struct packed {
    prec_mask_t prec;    // lanes to update
    word_t      data;    // data word, all lanes
    word_t      weight;  // weight word, all lanes
  } smul_req_t;          // 132 bits

  typedef struct packed {
    prec_mask_t lane_mask;  // lanes refreshed by this result
    word_t      result;     // lane products, unselected lanes held
  } smul_rsp_t;             // 68 bits

endpackage

/* rtl/lane_mult.sv */
/*
  Two-stage multiplier for one lane, product truncated to WIDTH bits.
  The low WIDTH bits match for signed and unsigned operands, so there
  is no sign handling. p_o holds its value between updates and a new
  pair may enter on every cycle.
*/
`timescale 1ns/100ps

module lane_mult #(
  parameter int WIDTH = 8
) (
  input  logic             clk,
  input  logic             rst_i,
  input  logic             en_i,
  input  logic [WIDTH-1:0] a_i,
  input  logic [WIDTH-1:0] b_i,
  output logic [WIDTH-1:0] p_o
);

  logic             s1_vld_q;  // stage 1 holds a live pair
  logic [WIDTH-1:0] a_q;       // stage 1 operand a
  logic [WIDTH-1:0] b_q;       // stage 1 operand b
  logic [WIDTH-1:0] prod;      // truncated product of stage 1

  //////////////////////////////////////////////////
  // stage 1, operand capture
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst_i) begin
      s1_vld_q <= 1'b0;
    end else begin
      s1_vld_q <= en_i;  // one cycle per enabled pair
    end
  end

  always_ff @(posedge clk) begin
    if (en_i) begin
      a_q <= a_i;
      b_q <= b_i;
    end
  end

  // the WIDTH-bit context drops the upper product bits
  assign prod = a_q * b_q;

  //////////////////////////////////////////////////
  // stage 2, result register
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst_i) begin
      p_o <= '0;
    end else if (s1_vld_q) begin
      p_o <= prod;  // otherwise hold last product
    end
  end

endmodule

/* rtl/split_mult32.sv */
/*
  Two-stage 32-bit lane multiplier made of 16x16 partial products.
  Only the low 32 product bits are kept, so the high x high term is
  never formed and only the low 16 bits of the cross terms matter.
  p_o holds its value until the next valid stage 1 entry.
*/
`timescale 1ns/100ps

module split_mult32 (
  input  logic              clk,
  input  logic              rst_i,
  input  logic              en_i,
  input  smul_pkg::lane32_t a_i,
  input  smul_pkg::lane32_t b_i,
  output smul_pkg::lane32_t p_o
);
  import smul_pkg::*;

  lane16_t a_lo;       // operand halves
  lane16_t a_hi;
  lane16_t b_lo;
  lane16_t b_hi;

  lane32_t pp_ll;      // low x low, full 32 bits
  lane16_t pp_hl;      // high x low, low half only
  lane16_t pp_lh;      // low x high, low half only

  logic    s1_vld_q;   // stage 1 holds live partial products
  lane32_t pp_ll_q;
  lane16_t pp_hl_q;
  lane16_t pp_lh_q;
  lane16_t cross_sum;  // cross terms, mod 2^16

  assign a_lo = a_i[HALF_W-1:0];
  assign a_hi = a_i[2*HALF_W-1:HALF_W];
  assign b_lo = b_i[HALF_W-1:0];
  assign b_hi = b_i[2*HALF_W-1:HALF_W];

  //////////////////////////////////////////////////
  // stage 1, partial products
  //////////////////////////////////////////////////
  assign pp_ll = a_lo * b_lo;  // 32 bit context, operands widened
  assign pp_hl = a_hi * b_lo;  // 16 bit context, upper bits shift out
  assign pp_lh = a_lo * b_hi;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      s1_vld_q <= 1'b0;
    end else begin
      s1_vld_q <= en_i;
    end
  end

  always_ff @(posedge clk) begin
    if (en_i) begin
      pp_ll_q <= pp_ll;
      pp_hl_q <= pp_hl;
      pp_lh_q <= pp_lh;
    end
  end

  //////////////////////////////////////////////////
  // stage 2, recombine
  //////////////////////////////////////////////////
  assign cross_sum = pp_hl_q + pp_lh_q;  // carry out lands above bit 31

  always_ff @(posedge clk) begin
    if (rst_i) begin
      p_o <= '0;
    end else if (s1_vld_q) begin
      p_o <= pp_ll_q + {cross_sum, {HALF_W{1'b0}}};  // cross terms at bit 16
    end
  end

endmodule

/* rtl/issue_ctrl.sv */
/*
  Issue control for the lane multipliers. lane_en_o is combinational
  from the strobe and the mask. The response strobe and mask come out
  two cycles later, in step with the lane pipelines. No back-pressure,
  a request may arrive on every cycle.
*/
`timescale 1ns/100ps

module issue_ctrl (
  input  logic                 clk,
  input  logic                 rst_i,
  input  logic                 req_valid_i,
  input  smul_pkg::prec_mask_t prec_i,
  output smul_pkg::prec_mask_t lane_en_o,
  output logic                 rsp_valid_o,
  output smul_pkg::prec_mask_t rsp_mask_o
);
  import smul_pkg::*;

  // one slot of the response delay line
  typedef struct packed {
    logic       vld;   // request issued
    prec_mask_t mask;  // lanes it updates
  } issue_stage_t;

  issue_stage_t s1_q;  // one cycle after issue
  issue_stage_t s2_q;  // two cycles, aligned with lane results

  //////////////////////////////////////////////////
  // lane enables
  //////////////////////////////////////////////////
  // a lane runs only on a strobe with its mask bit set
  assign lane_en_o = prec_i & {NUM_LANES{req_valid_i}};

  //////////////////////////////////////////////////
  // response delay line
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst_i) begin
      s1_q <= '0;
      s2_q <= '0;
    end else begin
      s1_q.vld  <= req_valid_i;
      s1_q.mask <= lane_en_o;  // zero on idle cycles
      s2_q      <= s1_q;
    end
  end

  assign rsp_valid_o = s2_q.vld;
  assign rsp_mask_o  = s2_q.mask;  // all-zero mask still gives a strobe

endmodule

/* rtl/smul_top.sv */
/*
  Lane-split integer multiplier, 64-bit data times 64-bit weight.
  Lanes are 8/8/16/32 bits wide and selected by the request mask.
  Each selected lane returns its product mod 2^width, unselected lanes
  keep their previous value. Fixed latency of 2 cycles, no
  back-pressure, up to two requests in flight.
*/
`timescale 1ns/100ps

module smul_top (
  input  logic                clk,
  input  logic                rst_i,
  input  logic                req_valid_i,
  input  smul_pkg::smul_req_t req_i,
  output logic                rsp_valid_o,
  output smul_pkg::smul_rsp_t rsp_o
);
  import smul_pkg::*;

  prec_mask_t lane_en;   // per lane enable, this cycle
  prec_mask_t rsp_mask;  // mask of the request now answered

  lane8_t  l0_a;
  lane8_t  l0_b;
  lane8_t  l0_p;
  lane8_t  l1_a;
  lane8_t  l1_b;
  lane8_t  l1_p;
  lane16_t l2_a;
  lane16_t l2_b;
  lane16_t l2_p;
  lane32_t l3_a;
  lane32_t l3_b;
  lane32_t l3_p;

  //////////////////////////////////////////////////
  // operand split
  //////////////////////////////////////////////////
  assign l0_a = req_i.data[LANE0_LSB +: $bits(lane8_t)];
  assign l0_b = req_i.weight[LANE0_LSB +: $bits(lane8_t)];
  assign l1_a = req_i.data[LANE1_LSB +: $bits(lane8_t)];
  assign l1_b = req_i.weight[LANE1_LSB +: $bits(lane8_t)];
  assign l2_a = req_i.data[LANE2_LSB +: $bits(lane16_t)];
  assign l2_b = req_i.weight[LANE2_LSB +: $bits(lane16_t)];
  assign l3_a = req_i.data[LANE3_LSB +: $bits(lane32_t)];
  assign l3_b = req_i.weight[LANE3_LSB +: $bits(lane32_t)];

  //////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////
  issue_ctrl u_issue_ctrl (
    .clk         (clk),
    .rst_i       (rst_i),
    .req_valid_i (req_valid_i),
    .prec_i      (req_i.prec),
    .lane_en_o   (lane_en),
    .rsp_valid_o (rsp_valid_o),
    .rsp_mask_o  (rsp_mask)
  );

  //////////////////////////////////////////////////
  // lanes
  //////////////////////////////////////////////////
  lane_mult #(.WIDTH($bits(lane8_t))) u_lane0 (
    .clk   (clk),
    .rst_i (rst_i),
    .en_i  (lane_en[0]),
    .a_i   (l0_a),
    .b_i   (l0_b),
    .p_o   (l0_p)
  );

  lane_mult #(.WIDTH($bits(lane8_t))) u_lane1 (
    .clk   (clk),
    .rst_i (rst_i),
    .en_i  (lane_en[1]),
    .a_i   (l1_a),
    .b_i   (l1_b),
    .p_o   (l1_p)
  );

  lane_mult #(.WIDTH($bits(lane16_t))) u_lane2 (
    .clk   (clk),
    .rst_i (rst_i),
    .en_i  (lane_en[2]),
    .a_i   (l2_a),
    .b_i   (l2_b),
    .p_o   (l2_p)
  );

  split_mult32 u_lane3 (  // 32 bit lane from 16 bit halves
    .clk   (clk),
    .rst_i (rst_i),
    .en_i  (lane_en[3]),
    .a_i   (l3_a),
    .b_i   (l3_b),
    .p_o   (l3_p)
  );

  // response word in lane order, lane 3 on top
  assign rsp_o = '{lane_mask: rsp_mask, result: {l3_p, l2_p, l1_p, l0_p}};

endmodule

/* verif/smul_tb.sv */
/*
  Testbench for smul_top. Random requests from a fixed seed are checked
  against a lane model kept here. Expected responses wait in a queue
  with the edge at which they are due, so latency, order, mask and
  result are all compared. The run stops at the first mismatch.
*/
`timescale 1ns/100ps

module smul_tb;
  import smul_pkg::*;

  localparam int SEED         = 32'hda34;
  localparam int RESET_CYCLES = 4;
  localparam int LATENCY      = 2;     // sample edge to response sample edge
  localparam int DRAIN_LIMIT  = 20;    // cycles to wait for the last responses
  localparam int WATCHDOG     = 5000;  // whole run, in cycles

  typedef struct packed {
    logic [31:0] due;     // edge index at which the strobe is sampled
    prec_mask_t  mask;
    word_t       result;
  } expect_t;

  logic      clk;
  logic      rst_i;
  logic      req_valid_i;
  smul_req_t req_i;
  logic      rsp_valid_o;
  smul_rsp_t rsp_o;

  expect_t     exp_q[$];   // responses still owed by the DUT
  expect_t     head;
  word_t       model_res;  // lane results as the DUT should hold them
  logic [31:0] cyc;        // rising edges so far

  smul_top UUT (
    .clk         (clk),
    .rst_i       (rst_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  //////////////////////////////////////////////////
  // reporting
  //////////////////////////////////////////////////
  task automatic abort_run;
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected) begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, expected);
      abort_run();
    end
  endtask

  //////////////////////////////////////////////////
  // lane model
  //////////////////////////////////////////////////
  function automatic int lane_lsb(input int n);
    case (n)
      0: return LANE0_LSB;
      1: return LANE1_LSB;
      2: return LANE2_LSB;
      default: return LANE3_LSB;
    endcase
  endfunction

  function automatic int lane_width(input int n);
    case (n)
      0, 1: return 8;
      2: return 16;
      default: return 32;
    endcase
  endfunction

  function automatic word_t lane_field(input int n);  // lane bits, in place
    return ((word_t'(1) << lane_width(n)) - 1) << lane_lsb(n);
  endfunction

  // product of lane n mod 2^width, placed at the lane position
  function automatic word_t lane_product(input word_t data, input word_t weight,
                                         input int n);
    word_t m;
    word_t a;
    word_t b;
    m = (word_t'(1) << lane_width(n)) - 1;
    a = (data >> lane_lsb(n)) & m;
    b = (weight >> lane_lsb(n)) & m;
    return ((a * b) & m) << lane_lsb(n);  // operands below 2^32, no overflow
  endfunction

  function automatic word_t rand_word();
    return {$urandom, $urandom};
  endfunction

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////
  task automatic issue(input prec_mask_t prec, input word_t data, input word_t weight);
    expect_t e;
    int      n;
    @(posedge clk);
    req_valid_i <= 1'b1;
    req_i       <= '{prec: prec, data: data, weight: weight};
    for (n = 0; n < NUM_LANES; n++) begin
      if (prec[n]) begin
        model_res = (model_res & ~lane_field(n)) | lane_product(data, weight, n);
      end
    end
    e.due    = cyc + 2 + LATENCY;  // cyc reads the count before this edge
    e.mask   = prec;
    e.result = model_res;
    exp_q.push_back(e);
  endtask

  task automatic idle;  // valid low, junk on the request bus
    @(posedge clk);
    req_valid_i <= 1'b0;
    req_i       <= '{prec: prec_mask_t'($urandom), data: rand_word(), weight: rand_word()};
  endtask

  task automatic drain;
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      if (waited >= DRAIN_LIMIT) begin
        $display("timeout: %0d responses never arrived", exp_q.size());
        abort_run();
      end else begin
        @(posedge clk);
        waited++;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // response checker
  //////////////////////////////////////////////////
  always @(negedge clk) begin  // outputs settled mid cycle
    if (!rst_i) begin
      if (rsp_valid_o) begin
        if (exp_q.size() == 0) begin
          $display("response strobe at %0t ns with no request outstanding", $time);
          abort_run();
        end else begin
          head = exp_q.pop_front();
          check_value("rsp_valid_o edge", cyc + 1, head.due);  // fixed latency
          check_value("rsp_o.lane_mask", rsp_o.lane_mask, head.mask);
          check_value("rsp_o.result", rsp_o.result, head.result);
        end
      end else if (exp_q.size() != 0 && exp_q[0].due <= cyc + 1) begin
        $display("response due at edge %0d missing at %0t ns", exp_q[0].due, $time);
        abort_run();
      end
    end
  end

  initial begin
    repeat (WATCHDOG) @(posedge clk);
    $display("watchdog expired after %0d cycles", WATCHDOG);
    abort_run();
  end

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////
  initial begin
    void'($urandom(SEED));
    cyc         <= '0;
    rst_i       <= 1'b1;
    req_valid_i <= 1'b0;
    req_i       <= '0;
    model_res   = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_i <= 1'b0;

    // reset state, no strobe while idle
    repeat (6) idle();
    @(negedge clk);
    check_value("rsp_valid_o", rsp_valid_o, 1'b0);
    check_value("rsp_o.lane_mask", rsp_o.lane_mask, '0);
    check_value("rsp_o.result", rsp_o.result, '0);
    issue(4'b0001, rand_word(), rand_word());  // other lanes must read zero
    idle();

    // 8 bit lanes, corners first
    issue(4'b0011, '1, '1);
    issue(4'b0011, 64'h0000_0000_0000_ff80, 64'h0000_0000_0000_7fff);
    repeat (40) issue(prec_mask_t'($urandom_range(1, 3)), rand_word(), rand_word());
    idle();

    // 16 and 32 bit lanes, high halves set for the cross products
    issue(4'b1100, '1, '1);
    issue(4'b1000, 64'h0001_0000_0000_0000, 64'h0001_0000_0000_0000);
    issue(4'b1000, 64'hffff_0001_0000_0000, 64'h0001_ffff_0000_0000);
    issue(4'b1100, 64'h8000_ffff_ffff_0000, 64'h7fff_8001_0001_0000);
    repeat (40) begin
      issue(prec_mask_t'($urandom_range(1, 3) << 2),
            rand_word() | 64'h0001_0000_0000_0000,
            rand_word() | 64'h0001_0000_0000_0000);
    end
    idle();

    // lane hold with partial and empty masks
    issue(4'b0000, rand_word(), rand_word());
    repeat (60) begin
      issue(prec_mask_t'($urandom_range(0, 15)), rand_word(), rand_word());
      if ($urandom_range(0, 3) == 0) issue(4'b0000, rand_word(), rand_word());
      repeat ($urandom_range(0, 2)) idle();
    end

    // back to back on every cycle, then random gaps
    repeat (50) issue(prec_mask_t'($urandom), rand_word(), rand_word());
    repeat (50) begin
      issue(prec_mask_t'($urandom), rand_word(), rand_word());
      repeat ($urandom_range(0, 3)) idle();
    end
    idle();

    drain();
    repeat (3) @(posedge clk);  // no stray strobes after the last one
    $display("TB PASSED");
    $finish;
  end

endmodule

/* vlog.f */
rtl/smul_pkg.sv
rtl/lane_mult.sv
rtl/split_mult32.sv
rtl/issue_ctrl.sv
rtl/smul_top.sv
verif/smul_tb.sv

/* Makefile */
# Verilator build and run of the lane-split multiplier testbench

VERILATOR ?= verilator
TOP       ?= smul_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= TB PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check the output for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
